//--- Bender.yml
package:
  name: wrr_mux

sources:
  # RTL in compile order, the package first
  - design/wrr_pkg.sv
  - design/client_skid_buf.sv
  - design/wrr_credit_mask.sv
  - design/rr_pointer_arb.sv
  - design/beat_out_reg.sv
  - design/wrr_mux_top.sv
  # Simulation only sources
  - target: test
    files:
      - verif/wrr_mux_assert.sv
      - verif/wrr_mux_tb.sv

//--- design/beat_out_reg.sv
`timescale 1ns/1ps

module beat_out_reg #(
    parameter int CLIENTS = 4
) (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic [CLIENTS-1:0]                   i_gnt,
    input  wrr_pkg::client_beat_t [CLIENTS-1:0] i_beats,
    output logic                                 o_can_take,
    output logic [CLIENTS-1:0]                   o_pop,
    output logic                                 o_valid,
    input  logic                                 i_out_ready,
    output wrr_pkg::out_beat_t                   o_beat
);

    import wrr_pkg::*;

    logic            r_valid;
    out_beat_t       r_beat;
    logic [ID_W-1:0] w_id;
    client_beat_t    w_sel;
    logic            w_load;

    // One-hot to binary plus the matching payload select
    always_comb begin
        w_id  = '0;
        w_sel = '0;
        for (int k = 0; k < CLIENTS; k++) begin
            if (i_gnt[k]) begin
                w_id  = ID_W'(k);
                w_sel = i_beats[k];
            end
        end
    end

    // The stage can take a beat when empty or when its beat leaves now
    assign o_can_take = !r_valid || i_out_ready;
    assign w_load     = (|i_gnt) && o_can_take;
    assign o_pop      = o_can_take ? i_gnt : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
        end else if (w_load) begin
            r_valid <= 1'b1;
        end else if (i_out_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Payload and id stay put until the output handshake
    always_ff @(posedge i_clk) begin
        if (w_load) begin
            r_beat <= out_beat_t'{id: w_id, data: w_sel.data};
        end
    end

    assign o_valid = r_valid;
    assign o_beat  = r_beat;

endmodule : beat_out_reg

//--- design/client_skid_buf.sv
`timescale 1ns/1ps

module client_skid_buf (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  wrr_pkg::client_beat_t i_beat,
    input  logic                  i_pop,
    output logic                  o_pending,
    output wrr_pkg::client_beat_t o_beat
);

    import wrr_pkg::*;

    // Occupancy flag of the single entry
    logic         r_pending;
    // Held payload, only written on an accepted transfer
    client_beat_t r_beat;
    logic         w_accept;

    // Ready comes from the occupancy flop
    // A pop in the same cycle frees the slot, so a new beat can follow
    // without a bubble and the client can stay pending back to back
    assign o_ready  = !r_pending || i_pop;
    assign w_accept = i_valid && o_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_pending <= 1'b0;
        end else if (w_accept) begin
            // A fresh beat wins over the pop of the old one
            r_pending <= 1'b1;
        end else if (i_pop) begin
            r_pending <= 1'b0;
        end
    end

    // The payload register follows the accept only
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_beat <= i_beat;
        end
    end

    assign o_pending = r_pending;
    assign o_beat    = r_beat;

endmodule : client_skid_buf

//--- design/rr_pointer_arb.sv
`timescale 1ns/1ps

module rr_pointer_arb #(
    parameter int CLIENTS = 4
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [CLIENTS-1:0] i_req,
    input  logic               i_enable,
    input  logic               i_take,
    output logic [CLIENTS-1:0] o_gnt
);

    localparam int PTR_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;

    // Client with the highest priority in the current cycle
    logic [PTR_W-1:0] r_ptr;
    logic [PTR_W-1:0] w_gnt_idx;
    logic             w_found;

    // Scan from the pointer upwards and wrap around at the last client
    // The first requester met in that order wins
    always_comb begin
        int idx;
        o_gnt     = '0;
        w_found   = 1'b0;
        w_gnt_idx = '0;
        for (int k = 0; k < CLIENTS; k++) begin
            idx = int'(r_ptr) + k;
            if (idx >= CLIENTS) begin
                idx = idx - CLIENTS;
            end
            if (i_enable && !w_found && i_req[idx]) begin
                w_found    = 1'b1;
                o_gnt[idx] = 1'b1;
                w_gnt_idx  = PTR_W'(idx);
            end
        end
    end

    // The winner drops to lowest priority once its grant is taken
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_ptr <= '0;
        end else if (i_take && w_found) begin
            if (w_gnt_idx == PTR_W'(CLIENTS - 1)) begin
                r_ptr <= '0;
            end else begin
                r_ptr <= w_gnt_idx + 1'b1;
            end
        end
    end

endmodule : rr_pointer_arb

//--- design/wrr_credit_mask.sv
`timescale 1ns/1ps

module wrr_credit_mask #(
    parameter int CLIENTS = 4
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic [CLIENTS-1:0]                    i_req,
    input  logic                                  i_hold,
    input  logic [CLIENTS-1:0][wrr_pkg::CRD_W-1:0] i_weight,
    input  logic [CLIENTS-1:0]                    i_take,
    output logic [CLIENTS-1:0]                    o_mask_req,
    output logic                                  o_replenish
);

    import wrr_pkg::*;

    // Number of grants each client has taken in the current round
    logic [CLIENTS-1:0][CRD_W-1:0] r_crd_cnt;
    // Count plus one, one bit wider so that it cannot wrap
    logic [CLIENTS-1:0][CRD_W:0]   w_cnt_incr;
    logic [CLIENTS-1:0][CRD_W-1:0] w_cnt_next;
    logic [CLIENTS-1:0]            w_has_crd;
    logic                          w_replenish;
    logic                          w_taken;

    // A client still has credit while one more grant stays within its weight
    always_comb begin
        for (int i = 0; i < CLIENTS; i++) begin
            w_cnt_incr[i] = {1'b0, r_crd_cnt[i]} + 1'b1;
            w_has_crd[i]  = (w_cnt_incr[i] <= {1'b0, i_weight[i]});
        end
    end

    // The round is over once none of the current requesters has credit
    // With no requester at all this is also high, which is harmless
    // because nothing is taken in that cycle
    assign w_replenish = ((i_req & w_has_crd) == '0);

    // During replenish every requester is eligible again
    // Hold blocks every request so that no new grant can start
    always_comb begin
        if (i_hold) begin
            o_mask_req = '0;
        end else if (w_replenish) begin
            o_mask_req = i_req;
        end else begin
            o_mask_req = i_req & w_has_crd;
        end
    end

    // Next counter values, used only on a cycle where a grant is taken
    // On replenish the taken grant already counts for the new round
    always_comb begin
        for (int i = 0; i < CLIENTS; i++) begin
            if (w_replenish) begin
                w_cnt_next[i] = i_take[i] ? CRD_W'(1) : '0;
            end else if (i_take[i]) begin
                w_cnt_next[i] = w_cnt_incr[i][CRD_W-1:0];
            end else begin
                w_cnt_next[i] = r_crd_cnt[i];
            end
        end
    end

    assign w_taken = |i_take;

    // Counters freeze under back-pressure and while nothing is granted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_crd_cnt <= '0;
        end else if (w_taken) begin
            r_crd_cnt <= w_cnt_next;
        end
    end

    assign o_replenish = w_replenish;

endmodule : wrr_credit_mask

//--- design/wrr_mux_top.sv
`timescale 1ns/1ps

module wrr_mux_top #(
    parameter int CLIENTS = 4
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic [CLIENTS-1:0]                    i_valid,
    output logic [CLIENTS-1:0]                    o_ready,
    input  wrr_pkg::client_beat_t [CLIENTS-1:0]  i_beat,
    input  logic [CLIENTS-1:0][wrr_pkg::CRD_W-1:0] i_weight,
    input  logic                                  i_hold,
    output logic                                  o_valid,
    input  logic                                  i_out_ready,
    output wrr_pkg::out_beat_t                    o_beat
);

    import wrr_pkg::*;

    logic [CLIENTS-1:0]               w_pending;
    client_beat_t [CLIENTS-1:0]       w_held_beat;
    logic [CLIENTS-1:0]               w_mask_req;
    logic [CLIENTS-1:0]               w_gnt;
    logic [CLIENTS-1:0]               w_pop;
    logic                             w_can_take;

    // One single-entry input stage per client
    for (genvar c = 0; c < CLIENTS; c++) begin : gen_client
        client_skid_buf client_skid_buf_i (
            .i_clk     (i_clk),
            .i_rst_n   (i_rst_n),
            .i_valid   (i_valid[c]),
            .o_ready   (o_ready[c]),
            .i_beat    (i_beat[c]),
            .i_pop     (w_pop[c]),
            .o_pending (w_pending[c]),
            .o_beat    (w_held_beat[c])
        );
    end

    // Credits filter the pending flags before the round-robin sees them
    wrr_credit_mask #(.CLIENTS(CLIENTS)) wrr_credit_mask_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (w_pending),
        .i_hold      (i_hold),
        .i_weight    (i_weight),
        .i_take      (w_pop),
        .o_mask_req  (w_mask_req),
        .o_replenish ()
    );

    // A grant only exists while the output stage has room for it
    rr_pointer_arb #(.CLIENTS(CLIENTS)) rr_pointer_arb_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (w_mask_req),
        .i_enable (w_can_take),
        .i_take   (|w_pop),
        .o_gnt    (w_gnt)
    );

    beat_out_reg #(.CLIENTS(CLIENTS)) beat_out_reg_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_gnt       (w_gnt),
        .i_beats     (w_held_beat),
        .o_can_take  (w_can_take),
        .o_pop       (w_pop),
        .o_valid     (o_valid),
        .i_out_ready (i_out_ready),
        .o_beat      (o_beat)
    );

endmodule : wrr_mux_top

//--- design/wrr_pkg.sv
package wrr_pkg;

    // Width of one client payload word
    parameter int DATA_W = 16;

    // Width of a credit counter and of a runtime weight
    // A weight of 0 is not supported, so the usable range is 1 to 15
    parameter int CRD_W = 4;

    // Width of a client number on the output side
    // It has to be wide enough for the client count chosen at the top level
    parameter int ID_W = 2;

    // One beat as offered by a client and held in its skid buffer
    typedef struct packed {
        logic [DATA_W-1:0] data;
    } client_beat_t;

    // One beat on the shared output port
    // The id field tells the consumer which client the payload came from
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } out_beat_t;

endpackage : wrr_pkg

//--- verif/wrr_mux_assert.sv
`timescale 1ns/1ps

module wrr_mux_assert #(
    parameter int CLIENTS = 4
) (
    input logic               i_clk,
    input logic               i_rst_n,
    input logic               i_valid,
    input logic               i_ready,
    input wrr_pkg::out_beat_t i_beat,
    input logic [CLIENTS-1:0] i_gnt
);

    // A stalled output beat must neither vanish nor change
    a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid && !i_ready |=> i_valid && $stable(i_beat))
        else $error("output beat changed or dropped under back-pressure");

    // Every skid buffer is empty on release, so the first edge loads nothing
    a_reset_empty: assert property (@(posedge i_clk) $rose(i_rst_n) |=> !i_valid)
        else $error("o_valid high one cycle after reset release");

    // The arbiter picks at most one client per cycle
    a_gnt_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n) $onehot0(i_gnt))
        else $error("internal grant has more than one bit set");

endmodule : wrr_mux_assert

// Attach the checks to every instance of the top level
bind wrr_mux_top wrr_mux_assert #(.CLIENTS(CLIENTS)) wrr_mux_assert_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (o_valid),
    .i_ready (i_out_ready),
    .i_beat  (o_beat),
    .i_gnt   (w_gnt)
);

//--- verif/wrr_mux_tb.sv
`timescale 1ns/1ps

module wrr_mux_tb;

    import wrr_pkg::*;

    localparam int CLIENTS   = 4;
    localparam int NUM_TESTS = 5;

    // One row of the stimulus table
    typedef struct packed {
        logic [CLIENTS-1:0][CRD_W-1:0] weight;
        logic [CLIENTS-1:0]            active;
        logic [7:0]                    beats;
        logic                          rand_ready;
        logic                          rand_valid;
        logic [7:0]                    hold_start;
        logic [7:0]                    hold_len;
        logic                          check_share;
        logic                          lone;
    } test_row_t;

    // Weights (client 3 first), active, beats per client, random ready, random valid,
    // hold start, hold length, weighted share check, lone requester check
    test_row_t tests [NUM_TESTS] = '{
        '{{4'd4, 4'd3, 4'd2, 4'd1}, 4'b1111, 8'd20, 1'b0, 1'b0, 8'd0, 8'd0, 1'b1, 1'b0},
        '{{4'd1, 4'd3, 4'd1, 4'd2}, 4'b1111, 8'd24, 1'b1, 1'b1, 8'd0, 8'd0, 1'b0, 1'b0},
        '{{4'd1, 4'd1, 4'd1, 4'd1}, 4'b0100, 8'd16, 1'b0, 1'b0, 8'd0, 8'd0, 1'b0, 1'b1},
        '{{4'd3, 4'd1, 4'd2, 4'd2}, 4'b1111, 8'd10, 1'b0, 1'b0, 8'd6, 8'd20, 1'b0, 1'b0},
        '{{4'd2, 4'd5, 4'd1, 4'd3}, 4'b1011, 8'd12, 1'b1, 1'b1, 8'd10, 8'd15, 1'b0, 1'b0}
    };

    logic                          i_clk;
    logic                          i_rst_n;
    logic [CLIENTS-1:0]            i_valid;
    logic [CLIENTS-1:0]            o_ready;
    client_beat_t [CLIENTS-1:0]    i_beat;
    logic [CLIENTS-1:0][CRD_W-1:0] i_weight;
    logic                          i_hold;
    logic                          o_valid;
    logic                          i_out_ready;
    out_beat_t                     o_beat;

    logic [31:0]       lcg_state = 32'hf5be_d590;
    // Expected payloads per client in the order they were accepted
    logic [DATA_W-1:0] exp_q [CLIENTS][$];
    // Client ids of the output beats, kept for the weighted share check
    int                share_ids [$];
    int                errors;
    int                checks;

    wrr_mux_top #(.CLIENTS(CLIENTS)) wrr_mux_top_i (.*);

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Client number in the top bits, sequence number below it
    function automatic logic [DATA_W-1:0] payload(input int client, input int seq);
        return {ID_W'(client), (DATA_W - ID_W)'(seq)};
    endfunction

    task automatic run_test(input int t);
        test_row_t          row;
        int                 sent [CLIENTS];
        logic [CLIENTS-1:0] taken;
        logic [31:0]        rnd;
        logic [DATA_W-1:0]  exp_data;
        int                 total;
        int                 cycle;
        int                 delivered;
        int                 hold_hits;
        int                 first_out;
        int                 last_out;
        int                 id;
        int                 round_len;
        int                 windows;
        int                 cnt;
        int                 test_errors;
        row         = tests[t];
        total       = 0;
        cycle       = 0;
        delivered   = 0;
        hold_hits   = 0;
        first_out   = -1;
        last_out    = -1;
        test_errors = 0;
        taken       = '0;
        share_ids.delete();
        for (int c = 0; c < CLIENTS; c++) begin
            sent[c] = 0;
            exp_q[c].delete();
            if (row.active[c]) begin
                total += row.beats;
            end
        end
        // Every test starts from a fresh reset so credits and pointer are 0
        @(negedge i_clk);
        i_rst_n     = 1'b0;
        i_valid     = '0;
        i_hold      = 1'b0;
        i_out_ready = 1'b0;
        i_weight    = row.weight;
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;
        #1;
        checks += 2;
        if (o_valid !== 1'b0) begin
            $display("mismatch o_valid after reset: got %h expected 0", o_valid);
            test_errors++;
        end
        if (o_ready !== '1) begin
            $display("mismatch o_ready after reset: got %h expected %h", o_ready, 4'hf);
            test_errors++;
        end
        while ((delivered < total) && (cycle < total * 20 + 50)) begin
            @(negedge i_clk);
            i_hold = (cycle >= int'(row.hold_start)) &&
                     (cycle < int'(row.hold_start) + int'(row.hold_len));
            rnd = lcg_next();
            i_out_ready = row.rand_ready ? rnd[25] : 1'b1;
            // A beat stays offered with stable data until it is accepted
            for (int c = 0; c < CLIENTS; c++) begin
                rnd = lcg_next();
                if (taken[c]) begin
                    i_valid[c] = 1'b0;
                end
                if (!i_valid[c] && row.active[c] && (sent[c] < row.beats) &&
                    (!row.rand_valid || rnd[24])) begin
                    i_valid[c]     = 1'b1;
                    i_beat[c].data = payload(c, sent[c]);
                end
            end
            // Inputs are settled here, so the coming edge's transfers are known
            #1;
            if (o_valid && i_out_ready) begin
                id = int'(o_beat.id);
                delivered++;
                checks++;
                hold_hits += i_hold ? 1 : 0;
                share_ids.push_back(id);
                if (first_out < 0) begin
                    first_out = cycle;
                end
                last_out = cycle;
                if (o_beat.id !== o_beat.data[DATA_W-1 -: ID_W]) begin
                    $display("mismatch o_beat.id: got %h expected %h",
                             o_beat.id, o_beat.data[DATA_W-1 -: ID_W]);
                    test_errors++;
                end
                if (exp_q[id].size() == 0) begin
                    $display("test %0d: beat %h from client %0d arrived while none was expected",
                             t, o_beat.data, id);
                    test_errors++;
                end else begin
                    exp_data = exp_q[id].pop_front();
                    if (o_beat.data !== exp_data) begin
                        $display("mismatch o_beat.data of client %0d: got %h expected %h",
                                 id, o_beat.data, exp_data);
                        test_errors++;
                    end
                end
            end
            for (int c = 0; c < CLIENTS; c++) begin
                taken[c] = i_valid[c] && o_ready[c];
                if (taken[c]) begin
                    exp_q[c].push_back(i_beat[c].data);
                    sent[c]++;
                end
            end
            cycle++;
        end
        // Drain a few cycles so that a duplicated beat would show up
        @(negedge i_clk);
        i_valid     = '0;
        i_hold      = 1'b0;
        i_out_ready = 1'b1;
        repeat (3) @(negedge i_clk);
        checks++;
        if (o_valid !== 1'b0) begin
            $display("mismatch o_valid after the last beat: got %h expected 0", o_valid);
            test_errors++;
        end
        for (int c = 0; c < CLIENTS; c++) begin
            if (row.active[c] && (sent[c] != row.beats)) begin
                $display("test %0d: client %0d could offer only %0d of %0d beats",
                         t, c, sent[c], row.beats);
                test_errors++;
            end
            if (exp_q[c].size() != 0) begin
                $display("test %0d: %0d beats of client %0d never arrived", t, exp_q[c].size(), c);
                test_errors++;
            end
        end
        // Only the beat already in the output stage may leave during hold
        if (hold_hits > 1) begin
            $display("test %0d: %0d beats were delivered while hold was high", t, hold_hits);
            test_errors++;
        end
        // Replenish must let a lone client through on every cycle
        if (row.lone && (last_out - first_out != int'(row.beats) - 1)) begin
            $display("test %0d: the lone client was not served back to back", t);
            test_errors++;
        end
        if (row.check_share) begin
            round_len = 0;
            windows   = 255;
            for (int c = 0; c < CLIENTS; c++) begin
                round_len += row.weight[c];
                if (int'(row.beats) / int'(row.weight[c]) < windows) begin
                    windows = int'(row.beats) / int'(row.weight[c]);
                end
            end
            // Each full round holds exactly weight grants per client
            for (int w = 0; w < windows; w++) begin
                for (int c = 0; c < CLIENTS; c++) begin
                    cnt = 0;
                    for (int k = 0; k < round_len; k++) begin
                        if (share_ids[w * round_len + k] == c) begin
                            cnt++;
                        end
                    end
                    checks++;
                    if (cnt != int'(row.weight[c])) begin
                        $display("mismatch grants of client %0d in round %0d: got %h expected %h",
                                 c, w, cnt, row.weight[c]);
                        test_errors++;
                    end
                end
            end
        end
        $display("test %0d done: %0d beats delivered, %0d errors", t, delivered, test_errors);
        errors += test_errors;
    endtask

    // Backstop in case a test loop itself stalls
    initial begin
        int budget;
        budget = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += $countones(tests[t].active) * int'(tests[t].beats) * 20 + 100;
        end
        repeat (budget) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", budget);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        i_rst_n     = 1'b0;
        i_valid     = '0;
        i_beat      = '0;
        i_weight    = '0;
        i_hold      = 1'b0;
        i_out_ready = 1'b0;
        errors      = 0;
        checks      = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : wrr_mux_tb

//--- wrr_mux_top.f
design/wrr_pkg.sv
design/client_skid_buf.sv
design/wrr_credit_mask.sv
design/rr_pointer_arb.sv
design/beat_out_reg.sv
design/wrr_mux_top.sv
verif/wrr_mux_assert.sv
verif/wrr_mux_tb.sv
